// File: verilog/stap_pkg.sv
/*
 * sTAP shared definitions
 * Widths, instruction opcodes, TAP-network select codes and TAP states
 */
`default_nettype none

package stap_pkg;

   // **************************************************
   // Instruction register
   // **************************************************
   localparam int IR_WIDTH = 8;
   typedef logic [IR_WIDTH-1:0] ir_t;

   // Public opcodes, anything else decodes as BYPASS
   localparam ir_t OPC_IDCODE      = 8'h0C;
   localparam ir_t OPC_TAPC_SELECT = 8'h11;
   localparam ir_t OPC_BYPASS      = 8'hFF;

   // Fixed pattern seen on TDO during an IR scan
   localparam ir_t IR_CAPTURE = 8'h01;

   // **************************************************
   // Data registers
   // **************************************************
   localparam int IDCODE_WIDTH = 32;
   typedef logic [IDCODE_WIDTH-1:0] idcode_t;

   // Per sub-TAP select code, two bits each
   typedef logic [1:0] tapc_code_t;
   localparam tapc_code_t TAPC_ISOLATED = 2'b00;
   localparam tapc_code_t TAPC_NORMAL   = 2'b01;
   localparam tapc_code_t TAPC_EXCLUDED = 2'b10;
   localparam tapc_code_t TAPC_SHADOW   = 2'b11;

   // **************************************************
   // IEEE 1149.1 controller states
   // **************************************************
   typedef enum logic [3:0] {
      TAP_TLR      = 4'h0,
      TAP_RTI      = 4'h1,
      TAP_SEL_DR   = 4'h2,
      TAP_CAP_DR   = 4'h3,
      TAP_SHIFT_DR = 4'h4,
      TAP_EX1_DR   = 4'h5,
      TAP_PAUSE_DR = 4'h6,
      TAP_EX2_DR   = 4'h7,
      TAP_UPD_DR   = 4'h8,
      TAP_SEL_IR   = 4'h9,
      TAP_CAP_IR   = 4'hA,
      TAP_SHIFT_IR = 4'hB,
      TAP_EX1_IR   = 4'hC,
      TAP_PAUSE_IR = 4'hD,
      TAP_EX2_IR   = 4'hE,
      TAP_UPD_IR   = 4'hF
   } tap_state_t;

endpackage

`default_nettype wire

// File: verilog/stap_fsm.sv
/*
 * sTAP controller
 * Sixteen-state TAP FSM with decoded strobes and falling-edge IR-path flag
 */
`timescale 1ns/1ns
`default_nettype none

module stap_fsm
   import stap_pkg::*;
   (
   input  logic       ftap_tck,
   input  logic       arst_n,
   input  logic       ftap_tms,
   output tap_state_t state,
   output logic       shift_ir,
   output logic       shift_dr,
   output logic       capture_ir,
   output logic       capture_dr,
   output logic       update_ir,
   output logic       update_dr,
   output logic       tlr,
   output logic       stap_selectwir_neg
   );

   tap_state_t next_state;
   logic       ir_path;

   // **************************************************
   // State register, TRST forces Test-Logic-Reset
   // **************************************************
   always_ff @(posedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
         state <= TAP_TLR;
      else
         state <= next_state;
   end

   // Standard 1149.1 transitions on TMS
   always_comb
   begin
      next_state = TAP_TLR;
      case (state)
         TAP_TLR      : next_state = ftap_tms ? TAP_TLR    : TAP_RTI;
         TAP_RTI      : next_state = ftap_tms ? TAP_SEL_DR : TAP_RTI;
         // DR column
         TAP_SEL_DR   : next_state = ftap_tms ? TAP_SEL_IR : TAP_CAP_DR;
         TAP_CAP_DR   : next_state = ftap_tms ? TAP_EX1_DR : TAP_SHIFT_DR;
         TAP_SHIFT_DR : next_state = ftap_tms ? TAP_EX1_DR : TAP_SHIFT_DR;
         TAP_EX1_DR   : next_state = ftap_tms ? TAP_UPD_DR : TAP_PAUSE_DR;
         TAP_PAUSE_DR : next_state = ftap_tms ? TAP_EX2_DR : TAP_PAUSE_DR;
         TAP_EX2_DR   : next_state = ftap_tms ? TAP_UPD_DR : TAP_SHIFT_DR;
         TAP_UPD_DR   : next_state = ftap_tms ? TAP_SEL_DR : TAP_RTI;
         // IR column
         TAP_SEL_IR   : next_state = ftap_tms ? TAP_TLR    : TAP_CAP_IR;
         TAP_CAP_IR   : next_state = ftap_tms ? TAP_EX1_IR : TAP_SHIFT_IR;
         TAP_SHIFT_IR : next_state = ftap_tms ? TAP_EX1_IR : TAP_SHIFT_IR;
         TAP_EX1_IR   : next_state = ftap_tms ? TAP_UPD_IR : TAP_PAUSE_IR;
         TAP_PAUSE_IR : next_state = ftap_tms ? TAP_EX2_IR : TAP_PAUSE_IR;
         TAP_EX2_IR   : next_state = ftap_tms ? TAP_UPD_IR : TAP_SHIFT_IR;
         TAP_UPD_IR   : next_state = ftap_tms ? TAP_SEL_DR : TAP_RTI;
         default      : next_state = TAP_TLR;
      endcase
   end

   // **************************************************
   // One-hot strobes for the register stage
   // **************************************************
   assign shift_ir   = (state == TAP_SHIFT_IR);
   assign shift_dr   = (state == TAP_SHIFT_DR);
   assign capture_ir = (state == TAP_CAP_IR);
   assign capture_dr = (state == TAP_CAP_DR);
   assign update_ir  = (state == TAP_UPD_IR);
   assign update_dr  = (state == TAP_UPD_DR);
   assign tlr        = (state == TAP_TLR);

   // Select-IR-Scan through Update-IR is the IR path
   assign ir_path = (state == TAP_SEL_IR)   | (state == TAP_CAP_IR) |
                    (state == TAP_SHIFT_IR) | (state == TAP_EX1_IR) |
                    (state == TAP_PAUSE_IR) | (state == TAP_EX2_IR) |
                    (state == TAP_UPD_IR);

   // Falling-edge copy so excluded TAPs switch in step with TDO
   always_ff @(negedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
         stap_selectwir_neg <= 1'b0;
      else
         stap_selectwir_neg <= ir_path;
   end

endmodule

`default_nettype wire

// File: verilog/stap_regs.sv
/*
 * sTAP register stage
 * Instruction register plus IDCODE, BYPASS and TAP-network select registers
 */
`timescale 1ns/1ns
`default_nettype none

module stap_regs
   import stap_pkg::*;
   #(
   parameter int      NUM_SUBTAPS  = 4,
   parameter idcode_t IDCODE_VALUE = 32'h1234_5E0F
   )
   (
   input  logic                         ftap_tck,
   input  logic                         arst_n,
   input  logic                         ftap_tdi,
   input  logic                         shift_ir,
   input  logic                         shift_dr,
   input  logic                         capture_ir,
   input  logic                         capture_dr,
   input  logic                         update_ir,
   input  logic                         update_dr,
   input  logic                         tlr,
   output logic [(2*NUM_SUBTAPS)-1:0]   tapc_select,
   output logic                         stap_tdo
   );

   localparam int SEL_WIDTH = 2 * NUM_SUBTAPS;

   // **************************************************
   // Internal signals
   // **************************************************
   ir_t                   ir;
   ir_t                   ir_shift;
   idcode_t               idcode_shift;
   logic                  bypass_shift;
   logic [SEL_WIDTH-1:0]  select_shift;
   logic                  instr_idcode;
   logic                  instr_select;
   logic                  dr_tdo;

   // **************************************************
   // Instruction register
   // **************************************************
   // Shift stage, LSB leaves first
   always_ff @(posedge ftap_tck)
   begin
      if (capture_ir)
         ir_shift <= IR_CAPTURE;
      else if (shift_ir)
         ir_shift <= {ftap_tdi, ir_shift[IR_WIDTH-1:1]};
   end

   // Parallel stage loads on the falling edge
   always_ff @(negedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
         ir <= OPC_IDCODE;
      else if (tlr)
         ir <= OPC_IDCODE;
      else if (update_ir)
         ir <= ir_shift;
   end

   // Unknown opcodes fall through to BYPASS
   assign instr_idcode = (ir == OPC_IDCODE);
   assign instr_select = (ir == OPC_TAPC_SELECT);

   // **************************************************
   // Data register shift stages
   // **************************************************
   always_ff @(posedge ftap_tck)
   begin
      if (capture_dr)
      begin
         // Each DR captures only when its instruction is active
         if (instr_idcode)
            idcode_shift <= IDCODE_VALUE;
         else if (instr_select)
            select_shift <= tapc_select;
         else
            bypass_shift <= 1'b0;
      end
      else if (shift_dr)
      begin
         if (instr_idcode)
            idcode_shift <= {ftap_tdi, idcode_shift[IDCODE_WIDTH-1:1]};
         else if (instr_select)
            select_shift <= {ftap_tdi, select_shift[SEL_WIDTH-1:1]};
         else
            bypass_shift <= ftap_tdi;
      end
   end

   // Select register update, cleared in Test-Logic-Reset
   always_ff @(negedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
         tapc_select <= '0;
      else if (tlr)
         tapc_select <= '0;
      else if (update_dr && instr_select)
         tapc_select <= select_shift;
   end

   // **************************************************
   // Serial output of the master shift path
   // **************************************************
   always_comb
   begin
      if (instr_idcode)
         dr_tdo = idcode_shift[0];
      else if (instr_select)
         dr_tdo = select_shift[0];
      else
         dr_tdo = bypass_shift;
   end

   // IR stage during Shift-IR, otherwise the selected DR
   assign stap_tdo = shift_ir ? ir_shift[0] : dr_tdo;

endmodule

`default_nettype wire

// File: verilog/stap_tapnw.sv
/*
 * sTAP network control
 * Per sub-TAP enable-TAP and enable-TDO decode, plus merged activity
 */
`timescale 1ns/1ns
`default_nettype none

module stap_tapnw
   import stap_pkg::*;
   #(
   parameter int NUM_SUBTAPS = 4
   )
   (
   input  logic                         stap_selectwir_neg,
   input  logic [(2*NUM_SUBTAPS)-1:0]   tapc_select,
   input  logic [NUM_SUBTAPS-1:0]       stapnw_atap_subtapactvi,
   output logic [NUM_SUBTAPS-1:0]       sftapnw_ftap_enabletap,
   output logic [NUM_SUBTAPS-1:0]       sftapnw_ftap_enabletdo,
   output logic                         atap_subtapactv_tapnw
   );

   // **************************************************
   // Enable decode per sub-TAP
   // **************************************************
   for (genvar m = 0; m < NUM_SUBTAPS; m++)
   begin : g_tap
      tapc_code_t code;

      assign code = tapc_select[(2*m)+1 -: 2];

      // Any code but ISOLATED keeps the sub-TAP clocked
      assign sftapnw_ftap_enabletap[m] = (code != TAPC_ISOLATED);

      // NORMAL always in the scan path, EXCLUDED only on the IR path
      assign sftapnw_ftap_enabletdo[m] = (code == TAPC_NORMAL) |
                                         (stap_selectwir_neg & (code == TAPC_EXCLUDED));
   end

   // Activity seen from above
   assign atap_subtapactv_tapnw = (|stapnw_atap_subtapactvi) | (|tapc_select);

endmodule

`default_nettype wire

// File: verilog/stap_tdo_chain.sv
/*
 * sTAP TDO chain
 * Threads the scan path through enabled sub-TAPs and drives TDO on the falling edge
 */
`timescale 1ns/1ns
`default_nettype none

module stap_tdo_chain
   import stap_pkg::*;
   #(
   parameter int NUM_SUBTAPS = 4
   )
   (
   input  logic                     ftap_tck,
   input  logic                     arst_n,
   input  logic                     shift_ir,
   input  logic                     shift_dr,
   input  logic                     stap_tdo,
   input  logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_enabletdo,
   input  logic [NUM_SUBTAPS-1:0]   sntapnw_atap_tdo,
   output logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_tdi,
   output logic                     atap_tdo,
   output logic                     atap_tdoen
   );

   // Serial value at each chain position with the master register at 0
   logic [NUM_SUBTAPS:0] chain;
   logic                 shifting;

   // **************************************************
   // Chain build in ascending sub-TAP index
   // **************************************************
   assign chain[0] = stap_tdo;

   for (genvar i = 0; i < NUM_SUBTAPS; i++)
   begin : g_link
      // Sub-TAP sees whatever arrives here
      assign sftapnw_ftap_tdi[i] = chain[i];
      // Enabled TAP inserts its own TDO and a disabled one is skipped
      assign chain[i+1] = sftapnw_ftap_enabletdo[i] ? sntapnw_atap_tdo[i] : chain[i];
   end

   assign shifting = shift_ir | shift_dr;

   // **************************************************
   // Falling-edge output stage
   // **************************************************
   always_ff @(negedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
      begin
         atap_tdo   <= 1'b0;
         atap_tdoen <= 1'b0;
      end
      else if (shifting)
      begin
         atap_tdo   <= chain[NUM_SUBTAPS];
         atap_tdoen <= 1'b1;
      end
      else
      begin
         // Park low outside Shift states
         atap_tdo   <= 1'b0;
         atap_tdoen <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: verilog/stap_top.sv
/*
 * sTAP top level
 * Master TAP controller driving a network of subordinate TAPs
 */
`timescale 1ns/1ns
`default_nettype none

module stap_top
   import stap_pkg::*;
   #(
   parameter int      NUM_SUBTAPS  = 4,
   parameter idcode_t IDCODE_VALUE = 32'h1234_5E0F
   )
   (
   // JTAG pins
   input  logic                     ftap_tck,
   input  logic                     arst_n,
   input  logic                     ftap_tms,
   input  logic                     ftap_tdi,
   output logic                     atap_tdo,
   output logic                     atap_tdoen,
   // Sub-TAP network
   output logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_enabletap,
   output logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_enabletdo,
   output logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_tdi,
   input  logic [NUM_SUBTAPS-1:0]   sntapnw_atap_tdo,
   input  logic [NUM_SUBTAPS-1:0]   stapnw_atap_subtapactvi,
   output logic                     atap_subtapactv_tapnw
   );

   // **************************************************
   // Internal signals
   // **************************************************
   logic                        shift_ir;
   logic                        shift_dr;
   logic                        capture_ir;
   logic                        capture_dr;
   logic                        update_ir;
   logic                        update_dr;
   logic                        tlr;
   logic                        stap_selectwir_neg;
   logic [(2*NUM_SUBTAPS)-1:0]  tapc_select;
   logic                        stap_tdo;

   // Controller, state kept internal for debug observation
   stap_fsm stap_fsm_inst (
      .ftap_tck           (ftap_tck),
      .arst_n             (arst_n),
      .ftap_tms           (ftap_tms),
      .state              (),
      .shift_ir           (shift_ir),
      .shift_dr           (shift_dr),
      .capture_ir         (capture_ir),
      .capture_dr         (capture_dr),
      .update_ir          (update_ir),
      .update_dr          (update_dr),
      .tlr                (tlr),
      .stap_selectwir_neg (stap_selectwir_neg)
   );

   stap_regs #(
      .NUM_SUBTAPS  (NUM_SUBTAPS),
      .IDCODE_VALUE (IDCODE_VALUE)
   ) stap_regs_inst (
      .ftap_tck    (ftap_tck),
      .arst_n      (arst_n),
      .ftap_tdi    (ftap_tdi),
      .shift_ir    (shift_ir),
      .shift_dr    (shift_dr),
      .capture_ir  (capture_ir),
      .capture_dr  (capture_dr),
      .update_ir   (update_ir),
      .update_dr   (update_dr),
      .tlr         (tlr),
      .tapc_select (tapc_select),
      .stap_tdo    (stap_tdo)
   );

   stap_tapnw #(
      .NUM_SUBTAPS (NUM_SUBTAPS)
   ) stap_tapnw_inst (
      .stap_selectwir_neg      (stap_selectwir_neg),
      .tapc_select             (tapc_select),
      .stapnw_atap_subtapactvi (stapnw_atap_subtapactvi),
      .sftapnw_ftap_enabletap  (sftapnw_ftap_enabletap),
      .sftapnw_ftap_enabletdo  (sftapnw_ftap_enabletdo),
      .atap_subtapactv_tapnw   (atap_subtapactv_tapnw)
   );

   stap_tdo_chain #(
      .NUM_SUBTAPS (NUM_SUBTAPS)
   ) stap_tdo_chain_inst (
      .ftap_tck               (ftap_tck),
      .arst_n                 (arst_n),
      .shift_ir               (shift_ir),
      .shift_dr               (shift_dr),
      .stap_tdo               (stap_tdo),
      .sftapnw_ftap_enabletdo (sftapnw_ftap_enabletdo),
      .sntapnw_atap_tdo       (sntapnw_atap_tdo),
      .sftapnw_ftap_tdi       (sftapnw_ftap_tdi),
      .atap_tdo               (atap_tdo),
      .atap_tdoen             (atap_tdoen)
   );

endmodule

`default_nettype wire

// File: verification/stap_props.sv
/*
 * sTAP bound checks
 * TDO-enable timing, Test-Logic-Reset clearing and enable decoding
 */
`timescale 1ns/1ns
`default_nettype none

module stap_props
   #(
   parameter int NUM_SUBTAPS = 4
   )
   (
   input logic                     ftap_tck,
   input logic                     arst_n,
   input logic                     shift_ir,
   input logic                     shift_dr,
   input logic                     tlr,
   input logic                     atap_tdoen,
   input logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_enabletap,
   input logic [NUM_SUBTAPS-1:0]   sftapnw_ftap_enabletdo
   );

   // Enable set on a falling edge must belong to a Shift state
   tdoen_in_shift : assert property (@(posedge ftap_tck) disable iff (!arst_n)
      atap_tdoen |-> (shift_ir || shift_dr))
      else $error("atap_tdoen high outside Shift-IR and Shift-DR");

   // Select register cleared by the falling edge in Test-Logic-Reset
   idle_in_tlr : assert property (@(posedge ftap_tck) disable iff (!arst_n)
      tlr |-> (sftapnw_ftap_enabletap == '0) && (sftapnw_ftap_enabletdo == '0))
      else $error("sub-TAP enables set in Test-Logic-Reset");

   // A TAP in the scan path is always clocked
   tdo_needs_tap : assert property (@(posedge ftap_tck) disable iff (!arst_n)
      (sftapnw_ftap_enabletdo & ~sftapnw_ftap_enabletap) == '0)
      else $error("enable-TDO without enable-TAP");

endmodule

bind stap_top stap_props #(
   .NUM_SUBTAPS (NUM_SUBTAPS)
) stap_props_inst (
   .ftap_tck               (ftap_tck),
   .arst_n                 (arst_n),
   .shift_ir               (shift_ir),
   .shift_dr               (shift_dr),
   .tlr                    (tlr),
   .atap_tdoen             (atap_tdoen),
   .sftapnw_ftap_enabletap (sftapnw_ftap_enabletap),
   .sftapnw_ftap_enabletdo (sftapnw_ftap_enabletdo)
);

`default_nettype wire

// File: verification/stap_tb.sv
/*
 * sTAP directed testbench
 * Drives the JTAG pins, models sub-TAPs as one-bit bypass flops
 * and checks IR, DR and TAP-network behavior
 */
`timescale 1ns/1ns
`default_nettype none

module stap_tb
   import stap_pkg::*;
   ;

   localparam int      N_SUB      = 4;
   localparam int      SEL_W      = 2 * N_SUB;
   localparam idcode_t IDCODE     = 32'h1234_5E0F;
   localparam int      MAX_CYCLES = 20000;

   // **************************************************
   // DUT pins and testbench state
   // **************************************************
   logic             ftap_tck;
   logic             arst_n;
   logic             ftap_tms;
   logic             ftap_tdi;
   logic             atap_tdo;
   logic             atap_tdoen;
   logic [N_SUB-1:0] sftapnw_ftap_enabletap;
   logic [N_SUB-1:0] sftapnw_ftap_enabletdo;
   logic [N_SUB-1:0] sftapnw_ftap_tdi;
   logic [N_SUB-1:0] sntapnw_atap_tdo;
   logic [N_SUB-1:0] stapnw_atap_subtapactvi;
   logic             atap_subtapactv_tapnw;

   logic [N_SUB-1:0] sub_q = '0;
   logic             tap_shift;
   logic             seen_tdo;
   logic             seen_tdoen;
   logic [SEL_W-1:0] cur_codes;
   logic [31:0]      lfsr_state;

   stap_top #(
      .NUM_SUBTAPS  (N_SUB),
      .IDCODE_VALUE (IDCODE)
   ) stap_top_inst (
      .ftap_tck                (ftap_tck),
      .arst_n                  (arst_n),
      .ftap_tms                (ftap_tms),
      .ftap_tdi                (ftap_tdi),
      .atap_tdo                (atap_tdo),
      .atap_tdoen              (atap_tdoen),
      .sftapnw_ftap_enabletap  (sftapnw_ftap_enabletap),
      .sftapnw_ftap_enabletdo  (sftapnw_ftap_enabletdo),
      .sftapnw_ftap_tdi        (sftapnw_ftap_tdi),
      .sntapnw_atap_tdo        (sntapnw_atap_tdo),
      .stapnw_atap_subtapactvi (stapnw_atap_subtapactvi),
      .atap_subtapactv_tapnw   (atap_subtapactv_tapnw)
   );

   // TCK with a 10 ns period
   initial
   begin
      ftap_tck = 1'b0;
      forever #5 ftap_tck = ~ftap_tck;
   end

   // Sub-TAPs as bypass flops that load only while enabled and shifting
   always @(posedge ftap_tck or negedge arst_n)
   begin
      if (!arst_n)
         sub_q <= '0;
      else if (tap_shift)
         sub_q <= (sub_q & ~sftapnw_ftap_enabletap) |
                  (sftapnw_ftap_tdi & sftapnw_ftap_enabletap);
   end

   assign sntapnw_atap_tdo = sub_q;

   // **************************************************
   // Failure reporting and checking
   // **************************************************
   task automatic abort_run(input string why);
      $display("%s", why);
      $display("*** FAILED ***");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp)
      begin
         $display("error %0t %s got %0h expected %0h", $time, name, got, exp);
         abort_run("value mismatch");
      end
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // One LFSR step per bit taken
   task automatic rand_bits(input int n, output logic [63:0] v);
      v = '0;
      for (int i = 0; i < n; i++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         v[i] = lfsr_state[0];
      end
   endtask

   // Expected enables from the select code rules
   function automatic logic [N_SUB-1:0] exp_enabletap(input logic [SEL_W-1:0] codes);
      logic [N_SUB-1:0] en;
      en = '0;
      for (int m = 0; m < N_SUB; m++)
      begin
         en[m] = (codes[2*m +: 2] != TAPC_ISOLATED);
      end
      return en;
   endfunction

   function automatic logic [N_SUB-1:0] exp_enabletdo(input logic [SEL_W-1:0] codes,
                                                      input logic ir_path);
      logic [N_SUB-1:0] en;
      en = '0;
      for (int m = 0; m < N_SUB; m++)
      begin
         en[m] = (codes[2*m +: 2] == TAPC_NORMAL) |
                 (ir_path & (codes[2*m +: 2] == TAPC_EXCLUDED));
      end
      return en;
   endfunction

   // **************************************************
   // TAP driving
   // **************************************************
   // One TCK cycle that starts and ends 2 ns after a rising edge
   task automatic tms_step(input logic tms, input logic tdi);
      ftap_tms = tms;
      ftap_tdi = tdi;
      @(negedge ftap_tck);
      #1;
      seen_tdo   = atap_tdo;
      seen_tdoen = atap_tdoen;
      @(posedge ftap_tck);
      #2;
   endtask

   // Five TMS-high cycles and then park in Run-Test/Idle
   task automatic goto_reset;
      repeat (5) tms_step(1'b1, 1'b0);
      tms_step(1'b0, 1'b0);
      cur_codes = '0;
      check("sftapnw_ftap_enabletap", 64'(sftapnw_ftap_enabletap), 64'(0));
      check("sftapnw_ftap_enabletdo", 64'(sftapnw_ftap_enabletdo), 64'(0));
      check("atap_tdoen", 64'(atap_tdoen), 64'(0));
   endtask

   // Shift-state body where TDO enable must be up on every bit
   task automatic shift_bits(input int n, input logic [63:0] din, output logic [63:0] dout);
      dout = '0;
      tap_shift = 1'b1;
      for (int i = 0; i < n; i++)
      begin
         tms_step(i == n - 1, din[i]);
         dout[i] = seen_tdo;
         check("atap_tdoen", 64'(seen_tdoen), 64'(1));
      end
      tap_shift = 1'b0;
   endtask

   // From idle through Shift-IR and Update-IR back to idle
   task automatic scan_ir(input int n, input logic [63:0] din, output logic [63:0] dout);
      tms_step(1'b1, 1'b0);
      tms_step(1'b1, 1'b0);
      tms_step(1'b0, 1'b0);
      tms_step(1'b0, 1'b0);
      // IR path seen by excluded TAPs
      check("sftapnw_ftap_enabletdo", 64'(sftapnw_ftap_enabletdo),
            64'(exp_enabletdo(cur_codes, 1'b1)));
      shift_bits(n, din, dout);
      tms_step(1'b1, 1'b0);
      tms_step(1'b0, 1'b0);
   endtask

   task automatic scan_dr(input int n, input logic [63:0] din, output logic [63:0] dout);
      tms_step(1'b1, 1'b0);
      tms_step(1'b0, 1'b0);
      tms_step(1'b0, 1'b0);
      check("sftapnw_ftap_enabletdo", 64'(sftapnw_ftap_enabletdo),
            64'(exp_enabletdo(cur_codes, 1'b0)));
      shift_bits(n, din, dout);
      tms_step(1'b1, 1'b0);
      tms_step(1'b0, 1'b0);
   endtask

   // **************************************************
   // Scan sequences with expected results
   // **************************************************
   // Opcode lands in the master IR and the extra bits check the IR path length
   task automatic load_ir(input ir_t opcode);
      int          k;
      int          n;
      logic [63:0] pad;
      logic [63:0] din;
      logic [63:0] dout;
      k = $countones(exp_enabletdo(cur_codes, 1'b1));
      n = 2 * IR_WIDTH + k;
      rand_bits(IR_WIDTH + k, pad);
      din = (64'(opcode) << (IR_WIDTH + k)) | pad;
      scan_ir(n, din, dout);
      check("ir capture", (dout >> k) & 64'hFF, 64'(IR_CAPTURE));
      for (int i = IR_WIDTH + k; i < n; i++)
      begin
         check("atap_tdo", 64'(dout[i]), 64'(din[i - IR_WIDTH - k]));
      end
   endtask

   task automatic check_idcode;
      int          k;
      logic [63:0] din;
      logic [63:0] dout;
      k = $countones(exp_enabletdo(cur_codes, 1'b0));
      rand_bits(IDCODE_WIDTH + k, din);
      scan_dr(IDCODE_WIDTH + k, din, dout);
      check("idcode", (dout >> k) & 64'hFFFF_FFFF, 64'(IDCODE));
   endtask

   // Bypass bit captures 0 and data appears 1 + k bits later
   task automatic check_bypass_delay;
      int          k;
      logic [63:0] din;
      logic [63:0] dout;
      k = $countones(exp_enabletdo(cur_codes, 1'b0));
      rand_bits(24, din);
      scan_dr(24, din, dout);
      check("bypass capture", 64'(dout[k]), 64'(0));
      for (int i = 1 + k; i < 24; i++)
      begin
         check("atap_tdo", 64'(dout[i]), 64'(din[i - 1 - k]));
      end
   endtask

   // Writes new codes and reads back the old ones
   task automatic write_select(input logic [SEL_W-1:0] codes);
      int          k;
      logic [63:0] dout;
      load_ir(OPC_TAPC_SELECT);
      k = $countones(exp_enabletdo(cur_codes, 1'b0));
      scan_dr(SEL_W + k, 64'(codes) << k, dout);
      check("tapc_select readback", (dout >> k) & 64'hFF, 64'(cur_codes));
      cur_codes = codes;
      check("sftapnw_ftap_enabletap", 64'(sftapnw_ftap_enabletap), 64'(exp_enabletap(codes)));
      check("sftapnw_ftap_enabletdo", 64'(sftapnw_ftap_enabletdo),
            64'(exp_enabletdo(codes, 1'b0)));
   endtask

   // **************************************************
   // Directed tests
   // **************************************************
   task automatic test_reset_state;
      check("sftapnw_ftap_enabletap", 64'(sftapnw_ftap_enabletap), 64'(0));
      check("sftapnw_ftap_enabletdo", 64'(sftapnw_ftap_enabletdo), 64'(0));
      check("atap_tdo", 64'(atap_tdo), 64'(0));
      check("atap_tdoen", 64'(atap_tdoen), 64'(0));
      tms_step(1'b0, 1'b0);
      // IDCODE is the reset instruction
      check_idcode();
   endtask

   task automatic test_ir_bypass;
      goto_reset();
      load_ir(OPC_IDCODE);
      check_idcode();
      load_ir(OPC_BYPASS);
      check_bypass_delay();
      // Unknown opcode decodes as BYPASS
      load_ir(8'h5A);
      check_bypass_delay();
   endtask

   task automatic test_select_write;
      logic [63:0] r;
      goto_reset();
      repeat (6)
      begin
         rand_bits(SEL_W, r);
         write_select(r[SEL_W-1:0]);
      end
   endtask

   task automatic test_normal_chain;
      logic [N_SUB-1:0] masks [4];
      logic [SEL_W-1:0] codes;
      logic [63:0]      r;
      rand_bits(N_SUB, r);
      masks = '{4'b0001, 4'b0110, 4'b1111, r[N_SUB-1:0]};
      goto_reset();
      foreach (masks[j])
      begin
         for (int m = 0; m < N_SUB; m++)
         begin
            codes[2*m +: 2] = masks[j][m] ? TAPC_NORMAL : TAPC_ISOLATED;
         end
         write_select(codes);
         load_ir(OPC_BYPASS);
         check_bypass_delay();
      end
   endtask

   task automatic test_excluded;
      goto_reset();
      // Tap 3 down to tap 0
      write_select({TAPC_EXCLUDED, TAPC_ISOLATED, TAPC_SHADOW, TAPC_EXCLUDED});
      load_ir(OPC_BYPASS);
      check_bypass_delay();
      write_select({TAPC_SHADOW, TAPC_EXCLUDED, TAPC_NORMAL, TAPC_ISOLATED});
      load_ir(OPC_BYPASS);
      check_bypass_delay();
   endtask

   task automatic test_activity;
      logic [63:0]      r;
      logic [N_SUB-1:0] act;
      goto_reset();
      for (int round = 0; round < 2; round++)
      begin
         if (round == 1)
         begin
            rand_bits(SEL_W, r);
            write_select(r[SEL_W-1:0] | 8'h01);
         end
         for (int j = 0; j < 5; j++)
         begin
            rand_bits(N_SUB, r);
            act = (j == 0) ? '0 : r[N_SUB-1:0];
            stapnw_atap_subtapactvi = act;
            tms_step(1'b0, 1'b0);
            check("atap_subtapactv_tapnw", 64'(atap_subtapactv_tapnw),
                  64'((act != '0) || (cur_codes != '0)));
         end
      end
      stapnw_atap_subtapactvi = '0;
   endtask

   // **************************************************
   // Sequence and watchdog
   // **************************************************
   initial
   begin
      for (int cyc = 0; cyc < MAX_CYCLES; cyc++)
      begin
         @(posedge ftap_tck);
      end
      abort_run("timeout: test sequence did not finish within the cycle limit");
   end

   initial
   begin
      ftap_tms                = 1'b1;
      ftap_tdi                = 1'b0;
      arst_n                  = 1'b0;
      stapnw_atap_subtapactvi = '0;
      tap_shift               = 1'b0;
      cur_codes               = '0;
      lfsr_state              = 32'h2d72_e993;
      // TRST for two cycles
      repeat (2) @(posedge ftap_tck);
      #2;
      arst_n = 1'b1;
      test_reset_state();
      test_ir_bypass();
      test_select_write();
      test_normal_chain();
      test_excluded();
      test_activity();
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

// File: src.f
verilog/stap_pkg.sv
verilog/stap_fsm.sv
verilog/stap_regs.sv
verilog/stap_tapnw.sv
verilog/stap_tdo_chain.sv
verilog/stap_top.sv
verification/stap_props.sv
verification/stap_tb.sv

// File: Makefile
# Verilator build and run for the sTAP testbench

VERILATOR ?= verilator
TOP       ?= stap_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LFLAGS    ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# The log decides the result, a missing pass line also counts as failure
run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF "*** FAILED ***" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "*** PASSED ***" $(LOG); then echo "no pass line in $(LOG)"; exit 1; fi

lint:
	$(VERILATOR) $(LFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
